// File: Makefile
SIM   ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP   ?= tb_mcu_cmd
FLIST ?= flist.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove build output"
	@echo "  help   list targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: bench/mcu_cmd_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_cmd_asserts (
  input logic                    clk,
  input logic                    arst_n,
  input logic                    cmd_ready,
  input logic                    param_ready,
  input logic                    mcu_rrq,
  input logic                    mcu_wrq,
  input logic                    mem_done,
  input logic                    mcu_rq_rdy,
  input mcu_cmd_pkg::mem_state_t state
);
  import mcu_cmd_pkg::*;

  a_req_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(mcu_rrq && mcu_wrq))
    else $error("read and write request high together");

  a_rrq_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    mcu_rrq |=> !mcu_rrq)
    else $error("read request longer than one cycle");

  a_wrq_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    mcu_wrq |=> !mcu_wrq)
    else $error("write request longer than one cycle");

  // host must hold off while an access is outstanding
  a_strobe_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (cmd_ready || param_ready) |-> state == mem_idle)
    else $error("host strobe outside idle state");

  a_done_after_rdy: assert property (@(posedge clk) disable iff (!arst_n)
    mem_done |-> $past(mcu_rq_rdy))
    else $error("mem_done without preceding ready");

endmodule

bind mem_access_fsm mcu_cmd_asserts asserts_i (
  .clk         (clk),
  .arst_n      (arst_n),
  .cmd_ready   (cmd_ready),
  .param_ready (param_ready),
  .mcu_rrq     (mcu_rrq),
  .mcu_wrq     (mcu_wrq),
  .mem_done    (mem_done),
  .mcu_rq_rdy  (mcu_rq_rdy),
  .state       (state)
);

`default_nettype wire

// File: bench/tb_mcu_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_cmd;
  import mcu_cmd_pkg::*;

  localparam byte_t   ECHO_BYTE   = 8'hA5;
  localparam mapper_t MAPPER_INIT = 3'd1;
  localparam int      NUM_CMDS    = 200;
  localparam longint  WATCHDOG_NS = NUM_CMDS * 16 * 12 * 8;

  logic    clk;
  logic    arst_n;
  logic    cmd_ready;
  logic    param_ready;
  byte_t   cmd_data;
  byte_t   param_data;
  byte_t   spi_data_out;
  mapper_t mcu_mapper;
  addr_t   rom_mask;
  addr_t   saveram_mask;
  addr_t   addr_out;
  logic    mcu_rrq;
  logic    mcu_wrq;
  logic    mem_done;
  logic    mcu_rq_rdy;
  byte_t   mcu_data_in;
  byte_t   mcu_data_out;

  // memory model and reference model
  byte_t      mem [256];
  byte_t      ref_mem [256];
  mapper_t    ref_mapper;
  addr_t      ref_rom;
  addr_t      ref_sram;
  addr_t      ref_addr;
  byte_t      ref_spi;
  byte_t      ref_op;
  byte_idx_t  ref_next;
  logic       req_expected;
  logic [31:0] stim_seed = 32'd85080;
  logic [31:0] mem_seed  = 32'd85080;

  mcu_cmd_top #(
    .ECHO_BYTE   (ECHO_BYTE),
    .MAPPER_INIT (MAPPER_INIT)
  ) dut_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .spi_data_out (spi_data_out),
    .mcu_mapper   (mcu_mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .addr_out     (addr_out),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mem_done     (mem_done),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .mcu_data_out (mcu_data_out)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic int unsigned lcg_pick(inout logic [31:0] st, input int unsigned n);
    st = st * 32'd1103515245 + 32'd12345;
    return int'(st[30:16]) % n;
  endfunction

  task automatic abort_run(input string why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  task automatic check_mapper(input string name, input mapper_t exp, input mapper_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      abort_run("output value mismatch");
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %06h, got %06h", $time, name, exp, act);
      abort_run("output value mismatch");
    end
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %02h, got %02h", $time, name, exp, act);
      abort_run("output value mismatch");
    end
  endtask

  task automatic check_outputs();
    check_mapper("mcu_mapper", ref_mapper, mcu_mapper);
    check_addr("rom_mask", ref_rom, rom_mask);
    check_addr("saveram_mask", ref_sram, saveram_mask);
    check_addr("addr_out", ref_addr, addr_out);
    check_byte("spi_data_out", ref_spi, spi_data_out);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_mem_done();
    int n;
    n = 0;
    while (mem_done !== 1'b1) begin
      @(posedge clk);
      #1;
      n++;
      if (n > 12) abort_run("mem_done did not arrive after a memory request");
    end
    @(posedge clk);
    #1;
  endtask

  // called one cycle after the strobe that started the access
  task automatic mem_access(input logic is_write, input int start_idx, input byte_t wdata);
    byte_t a;
    a = ref_addr[7:0];
    if (is_write) begin
      if (mcu_wrq !== 1'b1) abort_run("write request missing after write strobe");
      check_byte("mcu_data_out", wdata, mcu_data_out);
      ref_mem[a] = wdata;
    end else if (mcu_rrq !== 1'b1) begin
      abort_run("read request missing after read strobe");
    end
    wait_mem_done();
    if (!is_write) ref_spi = ref_mem[a];
    if (ref_op[AUTOINC_BIT] && start_idx >= 1 + int'(ref_op[SKIP_BIT])) begin
      ref_addr = ref_addr + 24'd1;
    end
    check_byte("memory", ref_mem[a], mem[a]);
  endtask

  task automatic send_cmd(input byte_t b);
    ref_op       = b;
    req_expected = (b[7:4] == OP_MEM_READ);
    cmd_data     = b;
    cmd_ready    = 1'b1;
    @(posedge clk);
    #1;
    cmd_ready = 1'b0;
    ref_next  = 4'd2;
    if (b[7:4] == OP_MAPPER) ref_mapper = b[2:0];
    if (b == OP_ECHO) ref_spi = ECHO_BYTE;
    if (b[7:4] == OP_MEM_READ) mem_access(1'b0, 1, 8'h00);
    check_outputs();
  endtask

  task automatic send_param(input byte_t p);
    byte_idx_t idx;
    idx          = ref_next;
    req_expected = (ref_op[7:4] == OP_MEM_READ) || (ref_op[7:4] == OP_MEM_WRITE);
    param_data   = p;
    param_ready  = 1'b1;
    @(posedge clk);
    #1;
    param_ready = 1'b0;
    ref_next    = (idx == 4'd15) ? idx : idx + 4'd1;
    case (ref_op[7:4])
      OP_SET_ADDR: begin
        if (idx == 4'd2) ref_addr = {p, 16'h0000};
        else if (idx == 4'd3) ref_addr[15:8] = p;
        else if (idx == 4'd4) ref_addr[7:0] = p;
      end
      OP_ROM_MASK: begin
        if (idx == 4'd2) ref_rom[23:16] = p;
        else if (idx == 4'd3) ref_rom[15:8] = p;
        else if (idx == 4'd4) ref_rom[7:0] = p;
      end
      OP_SRAM_MASK: begin
        if (idx == 4'd2) ref_sram[23:16] = p;
        else if (idx == 4'd3) ref_sram[15:8] = p;
        else if (idx == 4'd4) ref_sram[7:0] = p;
      end
      OP_MEM_READ:  mem_access(1'b0, int'(idx), p);
      OP_MEM_WRITE: mem_access(1'b1, int'(idx), p);
      default: ;
    endcase
    if (ref_op == OP_ECHO) ref_spi = ECHO_BYTE;
    else if (ref_op == OP_LOOPBACK) ref_spi = p;
    check_outputs();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory side responder
  ////////////////////////////////////////////////////////////////////////////

  initial begin : responder
    byte_t a;
    int    d;
    mcu_rq_rdy  = 1'b0;
    mcu_data_in = '0;
    forever begin
      @(posedge clk);
      #1;
      if (mcu_rrq === 1'b1 || mcu_wrq === 1'b1) begin
        if (!req_expected) abort_run("memory request without a triggering strobe");
        req_expected = 1'b0;
        a = addr_out[7:0];
        if (mcu_wrq === 1'b1) mem[a] = mcu_data_out;
        d = int'(lcg_pick(mem_seed, 4)) + 1;
        repeat (d) @(posedge clk);
        #1;
        mcu_rq_rdy  = 1'b1;
        mcu_data_in = mem[a];
        @(posedge clk);
        #1;
        mcu_rq_rdy = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run("timeout, the run took longer than the command budget");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int    kind;
    int    nparams;
    byte_t op;
    arst_n       = 1'b0;
    cmd_ready    = 1'b0;
    param_ready  = 1'b0;
    cmd_data     = '0;
    param_data   = '0;
    req_expected = 1'b0;
    // fill depends on every address bit
    for (int i = 0; i < 256; i++) begin
      mem[i]     = byte_t'(i * 29) ^ 8'h5A;
      ref_mem[i] = mem[i];
    end
    ref_mapper = MAPPER_INIT;
    ref_rom    = '0;
    ref_sram   = '0;
    ref_addr   = '0;
    ref_spi    = '0;
    ref_op     = '0;
    ref_next   = 4'd1;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_outputs();

    for (int c = 0; c < NUM_CMDS; c++) begin
      kind = int'(lcg_pick(stim_seed, 8));
      op   = byte_t'(lcg_pick(stim_seed, 16));
      case (kind)
        0: op = {OP_SET_ADDR, op[3:0]};
        1: op = {OP_ROM_MASK, op[3:0]};
        2: op = {OP_SRAM_MASK, op[3:0]};
        3: op = {OP_MAPPER, op[3:0]};
        4: op = {OP_MEM_READ, op[3:0]};
        5: op = {OP_MEM_WRITE, op[3:0]};
        6: op = OP_ECHO;
        default: op = OP_LOOPBACK;
      endcase
      // short counts cut a command off at the next command byte
      nparams = int'(lcg_pick(stim_seed, 8));
      send_cmd(op);
      for (int p = 0; p < nparams; p++) begin
        idle_cycles(int'(lcg_pick(stim_seed, 2)));
        send_param(byte_t'(lcg_pick(stim_seed, 256)));
      end
      idle_cycles(int'(lcg_pick(stim_seed, 3)));
    end

    idle_cycles(4);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
source/mcu_cmd_pkg.sv
source/cmd_frame_counter.sv
source/mem_access_fsm.sv
source/cart_config_regs.sv
source/mem_addr_reg.sv
source/response_reg.sv
source/mcu_cmd_top.sv
bench/mcu_cmd_asserts.sv
bench/tb_mcu_cmd.sv

// File: source/cart_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cart_config_regs #(
  parameter mcu_cmd_pkg::mapper_t MAPPER_INIT = 3'd1
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cmd_ready,
  input  logic                    param_ready,
  input  mcu_cmd_pkg::byte_t      cmd_data,
  input  mcu_cmd_pkg::byte_t      param_data,
  input  mcu_cmd_pkg::cmd_frame_t frame,
  output mcu_cmd_pkg::mapper_t    mcu_mapper,
  output mcu_cmd_pkg::addr_t      rom_mask,
  output mcu_cmd_pkg::addr_t      saveram_mask
);
  import mcu_cmd_pkg::*;

  logic rom_sel;
  logic sram_sel;

  assign rom_sel  = param_ready && frame.opcode[7:4] == OP_ROM_MASK;
  assign sram_sel = param_ready && frame.opcode[7:4] == OP_SRAM_MASK;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcu_mapper <= MAPPER_INIT;
    end else if (cmd_ready && cmd_data[7:4] == OP_MAPPER) begin
      mcu_mapper <= cmd_data[2:0];
    end
  end

  // masks load msb first, anything past parameter 4 is dropped
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rom_mask     <= '0;
      saveram_mask <= '0;
    end else if (rom_sel) begin
      case (frame.byte_idx)
        4'd2:    rom_mask[23:16] <= param_data;
        4'd3:    rom_mask[15:8]  <= param_data;
        4'd4:    rom_mask[7:0]   <= param_data;
        default: ;
      endcase
    end else if (sram_sel) begin
      case (frame.byte_idx)
        4'd2:    saveram_mask[23:16] <= param_data;
        4'd3:    saveram_mask[15:8]  <= param_data;
        4'd4:    saveram_mask[7:0]   <= param_data;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/cmd_frame_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_frame_counter (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cmd_ready,
  input  logic                    param_ready,
  input  mcu_cmd_pkg::byte_t      cmd_data,
  output mcu_cmd_pkg::cmd_frame_t frame
);
  import mcu_cmd_pkg::*;

  byte_t     opcode_q;
  byte_idx_t idx_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      opcode_q <= '0;
      idx_q    <= 4'd1;
    end else if (cmd_ready) begin
      opcode_q <= cmd_data;
      idx_q    <= 4'd2;
    end else if (param_ready && idx_q != 4'd15) begin
      idx_q <= idx_q + 4'd1;
    end
  end

  // command byte decodes in its own strobe cycle as index 1
  always_comb begin
    if (cmd_ready) begin
      frame.opcode   = cmd_data;
      frame.byte_idx = 4'd1;
    end else begin
      frame.opcode   = opcode_q;
      frame.byte_idx = idx_q;
    end
  end

endmodule

`default_nettype wire

// File: source/mcu_cmd_pkg.sv
`default_nettype none

package mcu_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;
  typedef logic [2:0]  mapper_t;
  typedef logic [23:0] addr_t;

  // 1 = command byte, 2 = first parameter, saturates at 15
  typedef logic [3:0]  byte_idx_t;

  // byte_idx is the index of the next parameter
  typedef struct packed {
    byte_t     opcode;
    byte_idx_t byte_idx;
  } cmd_frame_t;

  typedef enum logic [1:0] {
    mem_idle,
    mem_read_wait,
    mem_write_wait
  } mem_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////////////////////

  // upper nibble
  localparam logic [3:0] OP_SET_ADDR  = 4'h0;
  localparam logic [3:0] OP_ROM_MASK  = 4'h1;
  localparam logic [3:0] OP_SRAM_MASK = 4'h2;
  localparam logic [3:0] OP_MAPPER    = 4'h3;
  localparam logic [3:0] OP_MEM_READ  = 4'h8;
  localparam logic [3:0] OP_MEM_WRITE = 4'h9;

  // full byte
  localparam byte_t OP_ECHO     = 8'hF0;
  localparam byte_t OP_LOOPBACK = 8'hFF;

  // bits inside a memory opcode
  localparam int AUTOINC_BIT = 3;
  localparam int SKIP_BIT    = 4;

endpackage

`default_nettype wire

// File: source/mcu_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_cmd_top #(
  parameter mcu_cmd_pkg::byte_t   ECHO_BYTE   = 8'hA5,
  parameter mcu_cmd_pkg::mapper_t MAPPER_INIT = 3'd1
) (
  input  logic                 clk,
  input  logic                 arst_n,
  // host link
  input  logic                 cmd_ready,
  input  logic                 param_ready,
  input  mcu_cmd_pkg::byte_t   cmd_data,
  input  mcu_cmd_pkg::byte_t   param_data,
  output mcu_cmd_pkg::byte_t   spi_data_out,
  // cartridge config
  output mcu_cmd_pkg::mapper_t mcu_mapper,
  output mcu_cmd_pkg::addr_t   rom_mask,
  output mcu_cmd_pkg::addr_t   saveram_mask,
  // memory side
  output mcu_cmd_pkg::addr_t   addr_out,
  output logic                 mcu_rrq,
  output logic                 mcu_wrq,
  output logic                 mem_done,
  input  logic                 mcu_rq_rdy,
  input  mcu_cmd_pkg::byte_t   mcu_data_in,
  output mcu_cmd_pkg::byte_t   mcu_data_out
);
  import mcu_cmd_pkg::*;

  cmd_frame_t frame;

  ////////////////////////////////////////////////////////////////////////////
  // command context
  ////////////////////////////////////////////////////////////////////////////

  cmd_frame_counter frame_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_ready   (cmd_ready),
    .param_ready (param_ready),
    .cmd_data    (cmd_data),
    .frame       (frame)
  );

  mem_access_fsm fsm_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_ready   (cmd_ready),
    .param_ready (param_ready),
    .frame       (frame),
    .mcu_rq_rdy  (mcu_rq_rdy),
    .mcu_rrq     (mcu_rrq),
    .mcu_wrq     (mcu_wrq),
    .mem_done    (mem_done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // data registers
  ////////////////////////////////////////////////////////////////////////////

  cart_config_regs #(
    .MAPPER_INIT (MAPPER_INIT)
  ) config_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .frame        (frame),
    .mcu_mapper   (mcu_mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask)
  );

  mem_addr_reg addr_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .param_ready (param_ready),
    .param_data  (param_data),
    .frame       (frame),
    .mem_done    (mem_done),
    .addr_out    (addr_out)
  );

  response_reg #(
    .ECHO_BYTE (ECHO_BYTE)
  ) resp_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .param_data   (param_data),
    .mcu_data_in  (mcu_data_in),
    .frame        (frame),
    .mem_done     (mem_done),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .spi_data_out (spi_data_out),
    .mcu_data_out (mcu_data_out)
  );

endmodule

`default_nettype wire

// File: source/mem_access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_fsm (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cmd_ready,
  input  logic                    param_ready,
  input  mcu_cmd_pkg::cmd_frame_t frame,
  input  logic                    mcu_rq_rdy,
  output logic                    mcu_rrq,
  output logic                    mcu_wrq,
  output logic                    mem_done
);
  import mcu_cmd_pkg::*;

  mem_state_t state;
  logic       is_read;
  logic       is_write;
  logic       start_rd;
  logic       start_wr;

  assign is_read  = frame.opcode[7:4] == OP_MEM_READ;
  assign is_write = frame.opcode[7:4] == OP_MEM_WRITE;

  // reads start on the command byte and on every parameter,
  // writes only on parameters
  assign start_rd = is_read && (cmd_ready || param_ready);
  assign start_wr = is_write && param_ready;

  ////////////////////////////////////////////////////////////////////////////
  // request / wait
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= mem_idle;
      mcu_rrq  <= 1'b0;
      mcu_wrq  <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      mcu_rrq  <= 1'b0;
      mcu_wrq  <= 1'b0;
      mem_done <= 1'b0;
      case (state)
        mem_idle: begin
          if (start_rd) begin
            mcu_rrq <= 1'b1;
            state   <= mem_read_wait;
          end else if (start_wr) begin
            mcu_wrq <= 1'b1;
            state   <= mem_write_wait;
          end
        end
        mem_read_wait, mem_write_wait: begin
          // ready shares this clock and is sampled directly
          if (mcu_rq_rdy) begin
            mem_done <= 1'b1;
            state    <= mem_idle;
          end
        end
        default: begin
          state <= mem_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/mem_addr_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mem_addr_reg (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    param_ready,
  input  mcu_cmd_pkg::byte_t      param_data,
  input  mcu_cmd_pkg::cmd_frame_t frame,
  input  logic                    mem_done,
  output mcu_cmd_pkg::addr_t      addr_out
);
  import mcu_cmd_pkg::*;

  logic      addr_sel;
  logic      is_mem;
  logic      do_inc;
  byte_idx_t start_idx;

  assign addr_sel = param_ready && frame.opcode[7:4] == OP_SET_ADDR;
  assign is_mem   = frame.opcode[7:4] == OP_MEM_READ || frame.opcode[7:4] == OP_MEM_WRITE;

  // frame has already moved one past the byte that started the access
  assign start_idx = frame.byte_idx - 4'd1;
  assign do_inc    = mem_done && is_mem && frame.opcode[AUTOINC_BIT] &&
                     start_idx >= 4'd1 + {3'b000, frame.opcode[SKIP_BIT]};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr_out <= '0;
    end else if (addr_sel) begin
      case (frame.byte_idx)
        4'd2:    addr_out <= {param_data, 16'h0000};
        4'd3:    addr_out[15:8] <= param_data;
        4'd4:    addr_out[7:0]  <= param_data;
        default: ;
      endcase
    end else if (do_inc) begin
      addr_out <= addr_out + 24'd1;
    end
  end

endmodule

`default_nettype wire

// File: source/response_reg.sv
`timescale 1ns/1ps
`default_nettype none

module response_reg #(
  parameter mcu_cmd_pkg::byte_t ECHO_BYTE = 8'hA5
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cmd_ready,
  input  logic                    param_ready,
  input  mcu_cmd_pkg::byte_t      param_data,
  input  mcu_cmd_pkg::byte_t      mcu_data_in,
  input  mcu_cmd_pkg::cmd_frame_t frame,
  input  logic                    mem_done,
  input  logic                    mcu_rq_rdy,
  output mcu_cmd_pkg::byte_t      spi_data_out,
  output mcu_cmd_pkg::byte_t      mcu_data_out
);
  import mcu_cmd_pkg::*;

  byte_t rd_buf;

  // read data is only valid while ready is up
  always_ff @(posedge clk) begin
    if (mcu_rq_rdy) begin
      rd_buf <= mcu_data_in;
    end
    if (param_ready && frame.opcode[7:4] == OP_MEM_WRITE) begin
      mcu_data_out <= param_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      spi_data_out <= '0;
    end else if (mem_done && frame.opcode[7:4] == OP_MEM_READ) begin
      spi_data_out <= rd_buf;
    end else if ((cmd_ready || param_ready) && frame.opcode == OP_ECHO) begin
      spi_data_out <= ECHO_BYTE;
    end else if (param_ready && frame.opcode == OP_LOOPBACK) begin
      spi_data_out <= param_data;
    end
  end

endmodule

`default_nettype wire
